// File: build.f
hw/lc3b_pkg.sv
hw/lc3b_pipe_if.sv
hw/lc3b_fetch.sv
hw/lc3b_decode.sv
hw/lc3b_execute.sv
hw/lc3b_memwb.sv
hw/lc3b_pipe_ctrl.sv
hw/lc3b_core.sv
dv/lc3b_ref_model.sv
dv/tb_lc3b_core.sv

// File: dv/lc3b_ref_model.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LC-3b instruction-level reference model
// Runs a program image one instruction at a time,
// records every store it makes in order and counts its loads
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module lc3b_ref_model import lc3b_pkg::*; ();

	lc3b_word prog [256];
	lc3b_word mem [256];
	lc3b_word exp_addr [256];
	lc3b_word exp_data [256];
	lc3b_word exp_pc [256];
	int exp_count;
	int exp_loads;

	task automatic put_instr(input int idx, input lc3b_word w);
		prog[idx] = w;
	endtask

	task automatic put_data(input int idx, input lc3b_word w);
		mem[idx] = w;
	endtask

	function automatic logic [2:0] flags_of(input lc3b_word v);
		if (v[15])
			return 3'b100;
		else if (v == 16'h0000)
			return 3'b010;
		else
			return 3'b001;
	endfunction

	task automatic run_program();
		lc3b_word regs [8];
		lc3b_word pc;
		lc3b_word ir;
		lc3b_word src_a;
		lc3b_word src_b;
		lc3b_word ea;
		lc3b_word res;
		logic [2:0] cc;
		logic halted;
		int steps;
		int i;
		pc = 16'h0000;
		cc = 3'b010;
		halted = 1'b0;
		steps = 0;
		exp_count = 0;
		exp_loads = 0;
		for (i = 0; i < 8; i++)
			regs[i] = 16'h0000;
		while (!halted && steps < 4000)
		begin
			ir = prog[pc[8:1]];
			pc = pc + 16'd2;
			steps++;
			src_a = regs[ir[8:6]];
			src_b = ir[5] ? {{11{ir[4]}}, ir[4:0]} : regs[ir[2:0]];
			// Base plus word-scaled offset6
			ea = src_a + {{9{ir[5]}}, ir[5:0], 1'b0};
			case (ir[15:12])
				4'b0001, 4'b0101, 4'b1001:
				begin
					if (ir[15:12] == 4'b0001)
						res = src_a + src_b;
					else if (ir[15:12] == 4'b0101)
						res = src_a & src_b;
					else
						res = ~src_a;
					regs[ir[11:9]] = res;
					cc = flags_of(res);
				end
				// LEA leaves the condition codes alone on LC-3b
				4'b1110: regs[ir[11:9]] = pc + {{6{ir[8]}}, ir[8:0], 1'b0};
				4'b0110:
				begin
					res = mem[ea[8:1]];
					regs[ir[11:9]] = res;
					cc = flags_of(res);
					exp_loads++;
				end
				4'b0111:
				begin
					mem[ea[8:1]] = regs[ir[11:9]];
					exp_addr[exp_count] = ea;
					exp_data[exp_count] = regs[ir[11:9]];
					exp_pc[exp_count] = pc - 16'd2;
					exp_count++;
				end
				4'b0000:
				begin
					// BR nzp to itself ends the program
					if (ir == 16'h0FFF)
						halted = 1'b1;
					else if (|(ir[11:9] & cc))
						pc = pc + {{6{ir[8]}}, ir[8:0], 1'b0};
				end
				default: ;
			endcase
		end
	endtask

endmodule

// File: dv/tb_lc3b_core.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LC-3b core testbench
// Random program with forwarding, load-use and branch cases,
// store sequence checked against the reference model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tb_lc3b_core import lc3b_pkg::*; ();

	logic clk;
	logic rst_n;
	lc3b_word imem_addr;
	lc3b_word imem_rdata;
	lc3b_word dmem_addr;
	logic dmem_read;
	lc3b_word dmem_rdata;
	logic dmem_write;
	lc3b_word dmem_wdata;

	lc3b_word imem [256];
	lc3b_word dmem [256];
	string seg_of [256];
	int n_instr;
	int err_count;
	int store_count;
	int load_count;

	lc3b_core uut
	(
		.clk(clk),
		.i_rst_n(rst_n),
		.o_imem_addr(imem_addr),
		.i_imem_rdata(imem_rdata),
		.o_dmem_addr(dmem_addr),
		.o_dmem_read(dmem_read),
		.i_dmem_rdata(dmem_rdata),
		.o_dmem_write(dmem_write),
		.o_dmem_wdata(dmem_wdata)
	);

	lc3b_ref_model u_model ();

	// Both memories answer in the same cycle
	assign imem_rdata = imem[imem_addr[8:1]];
	assign dmem_rdata = dmem[dmem_addr[8:1]];

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic lc3b_word operate_rr(input logic [3:0] op, input int dr, input int sr1,
		input int sr2);
		return {op, dr[2:0], sr1[2:0], 3'b000, sr2[2:0]};
	endfunction

	function automatic lc3b_word operate_ri(input logic [3:0] op, input int dr, input int sr1,
		input int imm);
		return {op, dr[2:0], sr1[2:0], 1'b1, imm[4:0]};
	endfunction

	function automatic lc3b_word invert(input int dr, input int sr);
		return {op_not, dr[2:0], sr[2:0], 6'b111111};
	endfunction

	function automatic lc3b_word lea_instr(input int dr, input int off9);
		return {op_lea, dr[2:0], off9[8:0]};
	endfunction

	function automatic lc3b_word mem_access(input logic [3:0] op, input int r, input int base,
		input int off6);
		return {op, r[2:0], base[2:0], off6[5:0]};
	endfunction

	function automatic lc3b_word branch_to(input int nzp, input int off9);
		return {op_br, nzp[2:0], off9[8:0]};
	endfunction

	task automatic emit(input lc3b_word w, input string name);
		imem[n_instr] = w;
		seg_of[n_instr] = name;
		u_model.put_instr(n_instr, w);
		n_instr++;
	endtask

	task automatic build_program();
		int a;
		int b;
		int c;
		int k;
		int m;
		int skip;
		int cc_imm [3];
		lc3b_word v;
		cc_imm[0] = -3;
		cc_imm[1] = 0;
		cc_imm[2] = 5;
		for (k = 0; k < 256; k++)
		begin
			imem[k] = NOP_WORD;
			seg_of[k] = "none";
			u_model.put_instr(k, NOP_WORD);
			v = $urandom();
			dmem[k] = v;
			u_model.put_data(k, v);
		end
		n_instr = 0;
		for (k = 0; k < NUM_REGS; k++)
		begin
			emit(operate_ri(op_and, k, k, 0), "init");
			emit(operate_ri(op_add, k, k, $urandom_range(0, 31)), "init");
		end
		// Dependent chains fed from EX/MEM and MEM/WB
		for (k = 0; k < 4; k++)
		begin
			a = $urandom_range(0, 7);
			b = (a + 1) % 8;
			c = (a + 2) % 8;
			emit(operate_rr(op_add, a, $urandom_range(0, 7), $urandom_range(0, 7)), "forward");
			emit(operate_ri(op_add, b, a, $urandom_range(0, 31)), "forward");
			emit(operate_rr(op_and, c, a, b), "forward");
			emit(invert(a, c), "forward");
			emit(mem_access(op_str, a, $urandom_range(0, 7), $urandom_range(0, 63)), "forward");
			emit(mem_access(op_str, c, b, $urandom_range(0, 63)), "forward");
		end
		for (k = 0; k < 3; k++)
		begin
			a = $urandom_range(0, 7);
			b = (a + 3) % 8;
			emit(mem_access(op_ldr, a, $urandom_range(0, 7), $urandom_range(0, 63)), "load_use");
			emit(operate_ri(op_add, b, a, $urandom_range(0, 31)), "load_use");
			emit(mem_access(op_ldr, a, b, $urandom_range(0, 63)), "load_use");
			emit(mem_access(op_str, a, b, $urandom_range(0, 63)), "load_use");
			emit(mem_access(op_str, b, a, $urandom_range(0, 63)), "load_use");
		end
		// Every mask against n, z and p with a store in the branch shadow
		for (m = 1; m < 8; m++)
		begin
			for (k = 0; k < 3; k++)
			begin
				emit(operate_ri(op_and, 5, 5, 0), "branch");
				emit(operate_ri(op_add, 5, 5, cc_imm[k]), "branch");
				emit(branch_to(m, 1), "branch");
				emit(mem_access(op_str, 5, 6, m * 4 + k), "branch");
				emit(operate_ri(op_add, 6, 6, 1), "branch");
			end
		end
		for (k = 0; k < 30; k++)
		begin
			a = $urandom_range(0, 7);
			b = $urandom_range(0, 7);
			case ($urandom_range(0, 6))
				0: emit(operate_rr(op_add, a, b, $urandom_range(0, 7)), "random");
				1: emit(operate_ri(op_and, a, b, $urandom_range(0, 31)), "random");
				2: emit(invert(a, b), "random");
				3: emit(lea_instr(a, $urandom_range(0, 511)), "random");
				4: emit(mem_access(op_ldr, a, b, $urandom_range(0, 63)), "random");
				5: emit(mem_access(op_str, a, b, $urandom_range(0, 63)), "random");
				default:
				begin
					// Forward only, and never past the end of this block
					skip = $urandom_range(0, 3);
					if (skip > 29 - k)
						skip = 29 - k;
					emit(branch_to($urandom_range(0, 7), skip), "random");
				end
			endcase
		end
		for (k = 0; k < NUM_REGS; k++)
			emit(mem_access(op_str, k, 0, k), "final");
		emit(branch_to(7, -1), "final");
	endtask

	task automatic check_store();
		int idx;
		string name;
		lc3b_word pc_w;
		idx = store_count;
		assert (idx < u_model.exp_count)
		else
		begin
			err_count++;
			$display("Store to %h with data %h came after all %0d expected stores",
				dmem_addr, dmem_wdata, u_model.exp_count);
		end
		if (idx < u_model.exp_count)
		begin
			pc_w = u_model.exp_pc[idx];
			name = seg_of[pc_w[8:1]];
			assert (dmem_addr == u_model.exp_addr[idx])
			else
			begin
				err_count++;
				$display("Mismatch %s: store %0d address expected %h actual %h",
					name, idx, u_model.exp_addr[idx], dmem_addr);
			end
			assert (dmem_wdata == u_model.exp_data[idx])
			else
			begin
				err_count++;
				$display("Mismatch %s: store %0d data expected %h actual %h",
					name, idx, u_model.exp_data[idx], dmem_wdata);
			end
		end
		dmem[dmem_addr[8:1]] = dmem_wdata;
		store_count++;
	endtask

	// Outputs settle well before the falling edge
	always @(negedge clk)
	begin
		if (rst_n && dmem_write)
			check_store();
		if (rst_n && dmem_read)
			load_count++;
	end

	initial
	begin
		int cycles;
		rst_n = 1'b0;
		err_count = 0;
		store_count = 0;
		load_count = 0;
		void'($urandom(32'h7902_b3d6));
		build_program();
		u_model.run_program();
		repeat (16) @(posedge clk);
		#2 rst_n = 1'b1;
		@(negedge clk);
		assert (imem_addr == RESET_PC)
		else
		begin
			err_count++;
			$display("Mismatch reset: fetch address expected %h actual %h", RESET_PC, imem_addr);
		end
		assert (!dmem_write && !dmem_read)
		else
		begin
			err_count++;
			$display("Data memory strobe was high right after reset");
		end
		cycles = 0;
		while (store_count < u_model.exp_count && cycles < 5000)
		begin
			@(posedge clk);
			cycles++;
		end
		if (store_count < u_model.exp_count)
		begin
			err_count++;
			$display("Timeout after 5000 cycles with only %0d of %0d expected stores seen",
				store_count, u_model.exp_count);
		end
		// Window for stores that should never come
		repeat (40) @(posedge clk);
		// Each executed load strobes the read once in MEM
		assert (load_count == u_model.exp_loads)
		else
		begin
			err_count++;
			$display("Mismatch dmem_read: read strobes expected %0d actual %0d",
				u_model.exp_loads, load_count);
		end
		$display("Errors: %0d, stores seen %0d of %0d expected", err_count, store_count,
			u_model.exp_count);
		if (err_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: hw/lc3b_core.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LC-3b five-stage core
// Stage datapaths and pipeline control with plain memory ports
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module lc3b_core import lc3b_pkg::*;
(
	input logic clk,
	input logic i_rst_n,
	output lc3b_word o_imem_addr,
	input lc3b_word i_imem_rdata,
	output lc3b_word o_dmem_addr,
	output logic o_dmem_read,
	input lc3b_word i_dmem_rdata,
	output logic o_dmem_write,
	output lc3b_word o_dmem_wdata
);

	logic stall;
	logic flush;
	logic br_taken;
	lc3b_word br_target;
	lc3b_instr ifid_instr;
	lc3b_word ifid_pc;
	logic ifid_valid;
	lc3b_reg id_src1;
	lc3b_reg id_src2;
	lc3b_ctrl id_ctrl;
	lc3b_ctrl idex_ctrl;
	lc3b_word idex_a;
	lc3b_word idex_b;
	lc3b_word idex_pc;
	lc3b_instr idex_instr;
	logic [1:0] fwd_a_sel;
	logic [1:0] fwd_b_sel;
	lc3b_ctrl exmem_ctrl;
	lc3b_word exmem_addr;
	lc3b_word exmem_store_data;
	lc3b_nzp exmem_nzp_mask;

	wb_if wb ();
	stage_if ex_st ();
	stage_if mem_st ();

	lc3b_fetch u_fetch
	(
		.clk, .i_rst_n,
		.i_stall(stall), .i_flush(flush),
		.i_br_taken(br_taken), .i_br_target(br_target),
		.i_imem_rdata, .o_imem_addr,
		.o_ifid_instr(ifid_instr), .o_ifid_pc(ifid_pc), .o_ifid_valid(ifid_valid)
	);

	lc3b_decode u_decode
	(
		.clk, .i_rst_n,
		.i_stall(stall), .i_flush(flush),
		.i_ifid_instr(ifid_instr), .i_ifid_pc(ifid_pc), .i_ifid_valid(ifid_valid),
		.wb(wb), .ex_st(ex_st),
		.o_id_src1(id_src1), .o_id_src2(id_src2), .o_id_ctrl(id_ctrl),
		.o_idex_ctrl(idex_ctrl), .o_idex_a(idex_a), .o_idex_b(idex_b),
		.o_idex_pc(idex_pc), .o_idex_instr(idex_instr)
	);

	lc3b_execute u_execute
	(
		.clk, .i_rst_n,
		.i_flush(flush), .i_fwd_a_sel(fwd_a_sel), .i_fwd_b_sel(fwd_b_sel),
		.i_idex_ctrl(idex_ctrl), .i_idex_a(idex_a), .i_idex_b(idex_b),
		.i_idex_pc(idex_pc), .i_idex_instr(idex_instr),
		.wb(wb), .mem_st(mem_st),
		.o_exmem_ctrl(exmem_ctrl), .o_exmem_addr(exmem_addr),
		.o_exmem_store_data(exmem_store_data), .o_exmem_nzp_mask(exmem_nzp_mask)
	);

	lc3b_memwb u_memwb
	(
		.clk, .i_rst_n,
		.i_exmem_ctrl(exmem_ctrl), .i_exmem_addr(exmem_addr),
		.i_exmem_store_data(exmem_store_data), .i_exmem_nzp_mask(exmem_nzp_mask),
		.mem_st(mem_st), .i_dmem_rdata,
		.o_dmem_addr, .o_dmem_wdata, .o_dmem_read, .o_dmem_write,
		.o_br_taken(br_taken), .o_br_target(br_target),
		.wb(wb)
	);

	lc3b_pipe_ctrl u_pipe_ctrl
	(
		.clk, .i_rst_n,
		.i_id_src1(id_src1), .i_id_src2(id_src2), .i_id_ctrl(id_ctrl),
		.ex_st(ex_st), .mem_st(mem_st), .wb(wb),
		.i_br_taken(br_taken),
		.o_stall(stall), .o_flush(flush),
		.o_fwd_a_sel(fwd_a_sel), .o_fwd_b_sel(fwd_b_sel)
	);

endmodule

// File: hw/lc3b_decode.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LC-3b decode stage
// Control decode, register file with write-through, ID/EX register
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module lc3b_decode import lc3b_pkg::*;
(
	input logic clk,
	input logic i_rst_n,
	input logic i_stall,
	input logic i_flush,
	input lc3b_instr i_ifid_instr,
	input lc3b_word i_ifid_pc,
	input logic i_ifid_valid,
	wb_if.decode_mp wb,
	stage_if.src_mp ex_st,
	output lc3b_reg o_id_src1,
	output lc3b_reg o_id_src2,
	output lc3b_ctrl o_id_ctrl,
	output lc3b_ctrl o_idex_ctrl,
	output lc3b_word o_idex_a,
	output lc3b_word o_idex_b,
	output lc3b_word o_idex_pc,
	output lc3b_instr o_idex_instr
);

	lc3b_word regs [NUM_REGS];
	lc3b_word rd_a;
	lc3b_word rd_b;
	logic wb_write;
	logic bubble;

	always_comb
	begin
		o_id_ctrl = '0;
		case (i_ifid_instr.op_fmt.opcode)
			op_add, op_and:
			begin
				o_id_ctrl.aluop = (i_ifid_instr.op_fmt.opcode == op_add) ? alu_add : alu_and;
				o_id_ctrl.use_imm = i_ifid_instr.op_fmt.imm_flag;
				o_id_ctrl.load_reg = 1'b1;
				o_id_ctrl.load_cc = 1'b1;
				o_id_ctrl.sr1_needed = 1'b1;
				o_id_ctrl.sr2_needed = !i_ifid_instr.op_fmt.imm_flag;
			end
			op_not:
			begin
				o_id_ctrl.aluop = alu_not;
				o_id_ctrl.load_reg = 1'b1;
				o_id_ctrl.load_cc = 1'b1;
				o_id_ctrl.sr1_needed = 1'b1;
			end
			op_lea:
			begin
				o_id_ctrl.aluop = alu_pass;
				o_id_ctrl.is_lea = 1'b1;
				o_id_ctrl.load_reg = 1'b1;
			end
			op_ldr:
			begin
				o_id_ctrl.is_load = 1'b1;
				o_id_ctrl.load_reg = 1'b1;
				o_id_ctrl.load_cc = 1'b1;
				o_id_ctrl.sr1_needed = 1'b1;
			end
			op_str:
			begin
				o_id_ctrl.is_store = 1'b1;
				o_id_ctrl.sr1_needed = 1'b1;
				o_id_ctrl.sr2_needed = 1'b1;
			end
			// An empty mask is a no-op and travels as a bubble
			op_br: o_id_ctrl.is_branch = |i_ifid_instr.br_fmt.nzp;
			default: o_id_ctrl = '0;
		endcase
		if (!i_ifid_valid)
			o_id_ctrl = '0;
	end

	// STR reads its source data through the dr field
	assign o_id_src1 = i_ifid_instr.op_fmt.sr1;
	assign o_id_src2 = o_id_ctrl.is_store ? i_ifid_instr.op_fmt.dr : i_ifid_instr.op_fmt.imm5[2:0];

	assign wb_write = wb.wb_valid & wb.wb_load_reg;

	always_ff @(posedge clk)
	begin
		if (wb_write)
			regs[wb.wb_dest] <= wb.wb_data;
	end

	assign rd_a = (wb_write && wb.wb_dest == o_id_src1) ? wb.wb_data : regs[o_id_src1];
	assign rd_b = (wb_write && wb.wb_dest == o_id_src2) ? wb.wb_data : regs[o_id_src2];

	assign bubble = i_stall | i_flush;

	always_ff @(posedge clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
			o_idex_ctrl <= '0;
		else if (bubble)
			o_idex_ctrl <= '0;
		else
			o_idex_ctrl <= o_id_ctrl;
	end

	always_ff @(posedge clk)
	begin
		o_idex_a <= rd_a;
		o_idex_b <= rd_b;
		o_idex_pc <= i_ifid_pc;
		o_idex_instr <= bubble ? NOP_WORD : i_ifid_instr;
	end

	assign ex_st.valid = |o_idex_ctrl;
	assign ex_st.dest = o_idex_instr.op_fmt.dr;
	assign ex_st.load_reg = o_idex_ctrl.load_reg;
	assign ex_st.is_load = o_idex_ctrl.is_load;
	// Nothing computed yet in this stage
	assign ex_st.result = '0;

endmodule

// File: hw/lc3b_execute.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LC-3b execute stage
// Operand forwarding, ALU, address adder and the EX/MEM register
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module lc3b_execute import lc3b_pkg::*;
(
	input logic clk,
	input logic i_rst_n,
	input logic i_flush,
	input logic [1:0] i_fwd_a_sel,
	input logic [1:0] i_fwd_b_sel,
	input lc3b_ctrl i_idex_ctrl,
	input lc3b_word i_idex_a,
	input lc3b_word i_idex_b,
	input lc3b_word i_idex_pc,
	input lc3b_instr i_idex_instr,
	wb_if.ctrl_mp wb,
	stage_if.src_mp mem_st,
	output lc3b_ctrl o_exmem_ctrl,
	output lc3b_word o_exmem_addr,
	output lc3b_word o_exmem_store_data,
	output lc3b_nzp o_exmem_nzp_mask
);

	lc3b_word a_fwd;
	lc3b_word b_fwd;
	lc3b_word alu_b;
	lc3b_word alu_out;
	lc3b_word sext5;
	lc3b_word off6;
	lc3b_word off9;
	lc3b_word addr;
	lc3b_word exmem_result;
	lc3b_reg exmem_dest;
	logic pc_rel;

	function automatic lc3b_word fwd_mux(input logic [1:0] sel, input lc3b_word rf,
		input lc3b_word mem_val, input lc3b_word wb_val);
		case (sel)
			FWD_MEM: return mem_val;
			FWD_WB: return wb_val;
			default: return rf;
		endcase
	endfunction

	assign a_fwd = fwd_mux(i_fwd_a_sel, i_idex_a, mem_st.result, wb.wb_data);
	assign b_fwd = fwd_mux(i_fwd_b_sel, i_idex_b, mem_st.result, wb.wb_data);

	assign sext5 = {{11{i_idex_instr.op_fmt.imm5[4]}}, i_idex_instr.op_fmt.imm5};
	assign off6 = {{9{i_idex_instr.op_fmt.imm_flag}}, i_idex_instr.op_fmt.imm_flag,
		i_idex_instr.op_fmt.imm5, 1'b0};
	assign off9 = {{6{i_idex_instr.br_fmt.offset9[8]}}, i_idex_instr.br_fmt.offset9, 1'b0};

	// LEA and BR are relative to PC+2
	assign pc_rel = i_idex_ctrl.is_lea | i_idex_ctrl.is_branch;
	assign addr = pc_rel ? (i_idex_pc + off9) : (a_fwd + off6);

	assign alu_b = i_idex_ctrl.use_imm ? sext5 : b_fwd;

	always_comb
	begin
		case (i_idex_ctrl.aluop)
			alu_add: alu_out = a_fwd + alu_b;
			alu_and: alu_out = a_fwd & alu_b;
			alu_not: alu_out = ~a_fwd;
			default: alu_out = addr;
		endcase
	end

	always_ff @(posedge clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
			o_exmem_ctrl <= '0;
		else if (i_flush)
			o_exmem_ctrl <= '0;
		else
			o_exmem_ctrl <= i_idex_ctrl;
	end

	always_ff @(posedge clk)
	begin
		o_exmem_addr <= addr;
		o_exmem_store_data <= b_fwd;
		o_exmem_nzp_mask <= i_idex_instr.br_fmt.nzp;
		exmem_result <= alu_out;
		exmem_dest <= i_idex_instr.op_fmt.dr;
	end

	assign mem_st.valid = |o_exmem_ctrl;
	assign mem_st.dest = exmem_dest;
	assign mem_st.load_reg = o_exmem_ctrl.load_reg;
	assign mem_st.is_load = o_exmem_ctrl.is_load;
	assign mem_st.result = exmem_result;

endmodule

// File: hw/lc3b_fetch.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LC-3b fetch stage
// Program counter with branch redirect and the IF/ID register
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module lc3b_fetch import lc3b_pkg::*;
(
	input logic clk,
	input logic i_rst_n,
	input logic i_stall,
	input logic i_flush,
	input logic i_br_taken,
	input lc3b_word i_br_target,
	input lc3b_word i_imem_rdata,
	output lc3b_word o_imem_addr,
	output lc3b_instr o_ifid_instr,
	output lc3b_word o_ifid_pc,
	output logic o_ifid_valid
);

	lc3b_word pc;
	lc3b_word pc_plus2;

	assign pc_plus2 = pc + 16'd2;
	assign o_imem_addr = pc;

	always_ff @(posedge clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
			pc <= RESET_PC;
		else if (i_br_taken)
			pc <= i_br_target;
		else if (!i_stall)
			pc <= pc_plus2;
	end

	always_ff @(posedge clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
			o_ifid_valid <= 1'b0;
		else if (i_flush)
			o_ifid_valid <= 1'b0;
		else if (!i_stall)
			o_ifid_valid <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (i_flush)
			o_ifid_instr <= NOP_WORD;
		else if (!i_stall)
		begin
			o_ifid_instr <= i_imem_rdata;
			o_ifid_pc <= pc_plus2;
		end
	end

endmodule

// File: hw/lc3b_memwb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LC-3b memory and writeback stages
// Data access, branch decision, condition codes, MEM/WB register
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module lc3b_memwb import lc3b_pkg::*;
(
	input logic clk,
	input logic i_rst_n,
	input lc3b_ctrl i_exmem_ctrl,
	input lc3b_word i_exmem_addr,
	input lc3b_word i_exmem_store_data,
	input lc3b_nzp i_exmem_nzp_mask,
	stage_if.ctrl_mp mem_st,
	input lc3b_word i_dmem_rdata,
	output lc3b_word o_dmem_addr,
	output lc3b_word o_dmem_wdata,
	output logic o_dmem_read,
	output logic o_dmem_write,
	output logic o_br_taken,
	output lc3b_word o_br_target,
	wb_if.src_mp wb
);

	logic wb_valid_q;
	logic wb_load_reg_q;
	logic wb_load_cc_q;
	lc3b_reg wb_dest_q;
	lc3b_word wb_data_q;
	lc3b_nzp cc;
	lc3b_nzp wb_nzp;
	lc3b_nzp cc_eff;

	assign o_dmem_addr = i_exmem_addr;
	assign o_dmem_wdata = i_exmem_store_data;
	assign o_dmem_read = i_exmem_ctrl.is_load;
	assign o_dmem_write = i_exmem_ctrl.is_store;

	assign wb_nzp = {wb_data_q[15], wb_data_q == 16'h0000, !wb_data_q[15] && wb_data_q != 16'h0000};

	// cc written this edge is seen by the branch now in MEM
	assign cc_eff = (wb_valid_q && wb_load_cc_q) ? wb_nzp : cc;
	assign o_br_taken = i_exmem_ctrl.is_branch & |(i_exmem_nzp_mask & cc_eff);
	assign o_br_target = i_exmem_addr;

	always_ff @(posedge clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			wb_valid_q <= 1'b0;
			wb_load_reg_q <= 1'b0;
			wb_load_cc_q <= 1'b0;
			cc <= 3'b010;
		end
		else
		begin
			wb_valid_q <= mem_st.valid;
			wb_load_reg_q <= i_exmem_ctrl.load_reg;
			wb_load_cc_q <= i_exmem_ctrl.load_cc;
			if (wb_valid_q && wb_load_cc_q)
				cc <= wb_nzp;
		end
	end

	always_ff @(posedge clk)
	begin
		wb_dest_q <= mem_st.dest;
		wb_data_q <= i_exmem_ctrl.is_load ? i_dmem_rdata : mem_st.result;
	end

	assign wb.wb_valid = wb_valid_q;
	assign wb.wb_load_reg = wb_load_reg_q;
	assign wb.wb_dest = wb_dest_q;
	assign wb.wb_data = wb_data_q;

endmodule

// File: hw/lc3b_pipe_ctrl.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LC-3b pipeline control
// Load-use stall, branch flush and forwarding selects
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module lc3b_pipe_ctrl import lc3b_pkg::*;
(
	input logic clk,
	input logic i_rst_n,
	input lc3b_reg i_id_src1,
	input lc3b_reg i_id_src2,
	input lc3b_ctrl i_id_ctrl,
	stage_if.ctrl_mp ex_st,
	stage_if.ctrl_mp mem_st,
	wb_if.ctrl_mp wb,
	input logic i_br_taken,
	output logic o_stall,
	output logic o_flush,
	output logic [1:0] o_fwd_a_sel,
	output logic [1:0] o_fwd_b_sel
);

	lc3b_reg ex_src1;
	lc3b_reg ex_src2;
	logic ex_need1;
	logic ex_need2;
	logic mem_wr;
	logic wb_wr;

	function automatic logic [1:0] pick_fwd(input logic need, input lc3b_reg src,
		input logic mem_hit_en, input lc3b_reg mem_dest, input logic wb_hit_en,
		input lc3b_reg wb_dest);
		if (need && mem_hit_en && mem_dest == src)
			return FWD_MEM;
		else if (need && wb_hit_en && wb_dest == src)
			return FWD_WB;
		else
			return FWD_RF;
	endfunction

	assign o_stall = ex_st.valid & ex_st.is_load &
		((i_id_ctrl.sr1_needed & (ex_st.dest == i_id_src1)) |
		(i_id_ctrl.sr2_needed & (ex_st.dest == i_id_src2)));

	assign o_flush = i_br_taken;

	// Sources of the instruction now in ID/EX
	always_ff @(posedge clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			ex_need1 <= 1'b0;
			ex_need2 <= 1'b0;
		end
		else if (o_stall || o_flush)
		begin
			ex_need1 <= 1'b0;
			ex_need2 <= 1'b0;
		end
		else
		begin
			ex_need1 <= i_id_ctrl.sr1_needed;
			ex_need2 <= i_id_ctrl.sr2_needed;
		end
	end

	always_ff @(posedge clk)
	begin
		ex_src1 <= i_id_src1;
		ex_src2 <= i_id_src2;
	end

	// Load data is only taken from MEM/WB
	assign mem_wr = mem_st.valid & mem_st.load_reg & !mem_st.is_load;
	assign wb_wr = wb.wb_valid & wb.wb_load_reg;

	assign o_fwd_a_sel = pick_fwd(ex_need1, ex_src1, mem_wr, mem_st.dest, wb_wr, wb.wb_dest);
	assign o_fwd_b_sel = pick_fwd(ex_need2, ex_src2, mem_wr, mem_st.dest, wb_wr, wb.wb_dest);

endmodule

// File: hw/lc3b_pipe_if.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LC-3b pipeline interfaces
// Writeback bus and per-stage status for hazards and forwarding
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

interface wb_if import lc3b_pkg::*; ();
	logic wb_valid;
	logic wb_load_reg;
	lc3b_reg wb_dest;
	lc3b_word wb_data;

	modport src_mp (output wb_valid, output wb_load_reg, output wb_dest, output wb_data);
	modport decode_mp (input wb_valid, input wb_load_reg, input wb_dest, input wb_data);
	modport ctrl_mp (input wb_valid, input wb_load_reg, input wb_dest, input wb_data);
endinterface

interface stage_if import lc3b_pkg::*; ();
	logic valid;
	lc3b_reg dest;
	logic load_reg;
	logic is_load;
	lc3b_word result;

	modport src_mp (output valid, output dest, output load_reg, output is_load, output result);
	modport ctrl_mp (input valid, input dest, input load_reg, input is_load, input result);
endinterface

// File: hw/lc3b_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LC-3b core package
// Word types, instruction formats, opcodes and decoded control
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package lc3b_pkg;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;
	typedef logic [2:0] lc3b_nzp;

	typedef enum logic [3:0]
	{
		op_br  = 4'b0000,
		op_add = 4'b0001,
		op_and = 4'b0101,
		op_ldr = 4'b0110,
		op_str = 4'b0111,
		op_not = 4'b1001,
		op_lea = 4'b1110
	} lc3b_opcode;

	// Operate, LDR and STR share one layout, BR and LEA the other
	typedef union packed
	{
		struct packed
		{
			lc3b_opcode opcode;
			lc3b_reg dr;
			lc3b_reg sr1;
			logic imm_flag;
			logic [4:0] imm5;
		} op_fmt;
		struct packed
		{
			lc3b_opcode opcode;
			lc3b_nzp nzp;
			logic [8:0] offset9;
		} br_fmt;
	} lc3b_instr;

	typedef enum logic [1:0]
	{
		alu_add,
		alu_and,
		alu_not,
		alu_pass
	} lc3b_aluop;

	// All zero means a bubble
	typedef struct packed
	{
		lc3b_aluop aluop;
		logic use_imm;
		logic load_reg;
		logic load_cc;
		logic is_load;
		logic is_store;
		logic is_branch;
		logic is_lea;
		logic sr1_needed;
		logic sr2_needed;
	} lc3b_ctrl;

	localparam lc3b_word RESET_PC = 16'h0000;
	localparam int NUM_REGS = 8;
	// BR with an empty mask
	localparam lc3b_word NOP_WORD = 16'h0000;

	// Forwarding selects into execute
	localparam logic [1:0] FWD_RF = 2'd0;
	localparam logic [1:0] FWD_WB = 2'd1;
	localparam logic [1:0] FWD_MEM = 2'd2;

endpackage
